/* Makefile */
# Verilator build and run of the sram read subsystem testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_sram_subsys
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* axi_rd_if.sv */
// ----------------------------------------
// axi read address and read data channels
// master modport for the fetch side and
// slave modport for the sram controller
// ----------------------------------------
interface axi_rd_if;
	import mem_pkg::*;

	// read address channel
	logic [ADDR_W-1:0] ar_addr;
	logic              ar_valid;
	logic              ar_ready;

	// read data channel, single beat
	logic [DATA_W-1:0] r_data;
	resp_e             r_resp;
	logic              r_valid;
	logic              r_ready;

	modport master (
		output ar_addr, ar_valid, r_ready,
		input  ar_ready, r_data, r_resp, r_valid
	);

	modport slave (
		input  ar_addr, ar_valid, r_ready,
		output ar_ready, r_data, r_resp, r_valid
	);

endinterface

/* axi_sram_rd_slave.sv */
// ----------------------------------------
// axi read slave in front of the sram bank
// one address at a time, one beat back
// out of range addresses answer SLVERR
// with zero data
// ----------------------------------------
module axi_sram_rd_slave (
	input  logic                       clk,
	input  logic                       rst,
	axi_rd_if.slave                    rd,
	output logic                       sram_re_o,
	output logic [mem_pkg::WIDX_W-1:0] sram_idx_o,
	input  logic [mem_pkg::DATA_W-1:0] sram_rdata_i
);
	import mem_pkg::*;

	slv_state_e state_q;
	slv_state_e state_d;
	logic       ar_fire;
	logic       r_fire;
	logic       in_range;
	// address of the pending beat was outside the bank
	logic       err_q;

	// handshake outputs straight from the state
	assign rd.ar_ready = (state_q == WAIT_ADDR);
	assign rd.r_valid  = (state_q == WAIT_DATA);

	assign ar_fire = rd.ar_valid && rd.ar_ready;
	assign r_fire  = rd.r_valid && rd.r_ready;

	// bank covers byte addresses 0 to 1023
	assign in_range = (rd.ar_addr < MEM_BYTES);

	// word select from bits 9:2
	// low two bits are dropped
	assign sram_idx_o = rd.ar_addr[WIDX_W+1:2];
	// read pulse on address acceptance only
	assign sram_re_o  = ar_fire;

	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			WAIT_ADDR: begin
				if (ar_fire) begin
					state_d = WAIT_DATA;
				end
			end
			WAIT_DATA: begin
				// stays here while the master stalls
				if (r_fire) begin
					state_d = WAIT_ADDR;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= WAIT_ADDR;
			err_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			if (ar_fire) begin
				err_q <= !in_range;
			end
		end
	end

	// response and data for the beat
	assign rd.r_resp = err_q ? RESP_SLVERR : RESP_OKAY;
	assign rd.r_data = err_q ? '0 : sram_rdata_i;

	// a stalled beat keeps its data
	// depends on the sram read register not advancing
	a_r_data_stable: assert property (@(posedge clk) disable iff (rst)
		rd.r_valid && !rd.r_ready |=> $stable(rd.r_data))
		else $error("r_data changed while the beat was stalled");

endmodule

/* fetch_master.sv */
// ----------------------------------------
// fetch master for the axi read channel
// two-entry request queue, issue FSM and a
// result hold register that takes stalls
// ----------------------------------------
module fetch_master (
	input  logic                       clk,
	input  logic                       rst,
	axi_rd_if.master                   rd,
	input  logic                       req_valid_i,
	input  logic [mem_pkg::ADDR_W-1:0] req_addr_i,
	output logic                       req_ready_o,
	output logic                       res_valid_o,
	output logic [mem_pkg::DATA_W-1:0] res_data_o,
	output logic                       res_err_o,
	input  logic                       res_ready_i
);
	import mem_pkg::*;

	// request queue
	logic [ADDR_W-1:0] q_addr [2];
	logic              wr_ptr_q;
	logic              rd_ptr_q;
	logic [1:0]        count_q;
	// goes high the cycle after reset is released
	logic              live_q;
	logic              push;
	logic              pop;

	// issue FSM
	mst_state_e        state_q;
	mst_state_e        state_d;
	logic              ar_fire;
	logic              r_fire;

	// result hold register
	logic              hold_valid_q;
	logic [DATA_W-1:0] hold_data_q;
	logic              hold_err_q;

	// room while fewer than two entries wait
	assign req_ready_o = live_q && (count_q != 2'd2);
	assign push = req_valid_i && req_ready_o;
	// head leaves on the address handshake
	assign pop  = ar_fire;

	always_ff @(posedge clk) begin
		if (push) begin
			q_addr[wr_ptr_q] <= req_addr_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			live_q   <= 1'b0;
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q  <= 2'd0;
		end else begin
			live_q <= 1'b1;
			if (push) begin
				wr_ptr_q <= !wr_ptr_q;
			end
			if (pop) begin
				rd_ptr_q <= !rd_ptr_q;
			end
			count_q <= count_q + {1'b0, push} - {1'b0, pop};
		end
	end

	// read channel drive
	assign rd.ar_valid = (state_q == M_ADDR);
	assign rd.ar_addr  = q_addr[rd_ptr_q];
	// take a beat only into an empty hold register
	assign rd.r_ready  = !hold_valid_q;

	assign ar_fire = rd.ar_valid && rd.ar_ready;
	assign r_fire  = rd.r_valid && rd.r_ready;

	// M_HOLD means the beat is there but the hold register is full
	always_comb begin
		state_d = state_q;
		case (state_q)
			M_IDLE: begin
				if (count_q != 2'd0) begin
					state_d = M_ADDR;
				end
			end
			M_ADDR: begin
				if (ar_fire) begin
					state_d = M_DATA;
				end
			end
			M_DATA, M_HOLD: begin
				if (r_fire) begin
					// go straight on if another entry waits
					state_d = (count_q != 2'd0) ? M_ADDR : M_IDLE;
				end else if (rd.r_valid) begin
					state_d = M_HOLD;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q      <= M_IDLE;
			hold_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (r_fire) begin
				hold_valid_q <= 1'b1;
			end else if (res_ready_i) begin
				hold_valid_q <= 1'b0;
			end
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (r_fire) begin
			hold_data_q <= rd.r_data;
			hold_err_q  <= (rd.r_resp == RESP_SLVERR);
		end
	end

	assign res_valid_o = hold_valid_q;
	assign res_data_o  = hold_data_q;
	assign res_err_o   = hold_err_q;

	// waiting address keeps valid and payload until the slave takes it
	a_ar_addr_stable: assert property (@(posedge clk) disable iff (rst)
		rd.ar_valid && !rd.ar_ready |=> rd.ar_valid && $stable(rd.ar_addr))
		else $error("ar_addr changed while waiting for ar_ready");

endmodule

/* mem_pkg.sv */
// ----------------------------------------
// widths, bank geometry, response codes and
// FSM state types for the sram read path
// imported by the read interface and by
// every module of the subsystem
// ----------------------------------------
package mem_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// one strobe bit per byte lane
	localparam int BYTE_W = 8;
	localparam int STRB_W = DATA_W / BYTE_W;

	// bank geometry
	localparam int MEM_WORDS = 256;
	localparam int WIDX_W = $clog2(MEM_WORDS);
	// first byte address past the bank
	localparam int unsigned MEM_BYTES = MEM_WORDS * 4;

	// read response codes, axi encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// slave read controller
	typedef enum logic {
		WAIT_ADDR,
		WAIT_DATA
	} slv_state_e;

	// fetch master issue FSM
	typedef enum logic [1:0] {
		M_IDLE,
		M_ADDR,
		M_DATA,
		M_HOLD
	} mst_state_e;

endpackage

/* sources.f */
mem_pkg.sv
axi_rd_if.sv
sram_bank.sv
axi_sram_rd_slave.sv
fetch_master.sv
sram_subsys_top.sv
tb_sram_subsys.sv

/* sram_bank.sv */
// ----------------------------------------
// word-wide synchronous sram bank
// byte-masked write port for loading and
// a registered read port that only moves
// when its enable is high
// ----------------------------------------
module sram_bank (
	input  logic                       clk,
	input  logic                       we_i,
	input  logic [mem_pkg::WIDX_W-1:0] widx_w_i,
	input  logic [mem_pkg::DATA_W-1:0] wdata_i,
	input  logic [mem_pkg::STRB_W-1:0] wstrb_i,
	input  logic                       re_i,
	input  logic [mem_pkg::WIDX_W-1:0] widx_r_i,
	output logic [mem_pkg::DATA_W-1:0] rdata_o
);
	import mem_pkg::*;

	// storage, cleared at power up
	logic [DATA_W-1:0] mem [MEM_WORDS] = '{default: '0};

	// read data register
	logic [DATA_W-1:0] rdata_q;

	// write side
	// each strobe bit opens one byte lane
	always_ff @(posedge clk) begin
		if (we_i) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wstrb_i[b]) begin
					mem[widx_w_i][b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// read side
	// data shows up the cycle after the enable
	// a write to the same word on this edge is not seen yet
	always_ff @(posedge clk) begin
		if (re_i) begin
			rdata_q <= mem[widx_r_i];
		end
	end

	// holds its value while re_i stays low
	assign rdata_o = rdata_q;

endmodule

/* sram_subsys_top.sv */
// ----------------------------------------
// sram read subsystem top level
// fetch master, axi read slave and sram
// bank joined here, plain ports outside
// load port fills the bank directly
// ----------------------------------------
module sram_subsys_top (
	input  logic                       clk,
	input  logic                       rst,
	// word requests
	input  logic                       req_valid_i,
	input  logic [mem_pkg::ADDR_W-1:0] req_addr_i,
	output logic                       req_ready_o,
	// results
	output logic                       res_valid_o,
	output logic [mem_pkg::DATA_W-1:0] res_data_o,
	output logic                       res_err_o,
	input  logic                       res_ready_i,
	// memory load, one write per strobe
	input  logic                       load_we_i,
	input  logic [mem_pkg::WIDX_W-1:0] load_idx_i,
	input  logic [mem_pkg::DATA_W-1:0] load_data_i,
	input  logic [mem_pkg::STRB_W-1:0] load_strb_i
);
	import mem_pkg::*;

	// slave to sram read port
	logic              sram_re;
	logic [WIDX_W-1:0] sram_idx;
	logic [DATA_W-1:0] sram_rdata;

	// read channel between master and slave
	axi_rd_if rd_bus ();

	fetch_master u_master (
		.clk         (clk),
		.rst         (rst),
		.rd          (rd_bus),
		.req_valid_i (req_valid_i),
		.req_addr_i  (req_addr_i),
		.req_ready_o (req_ready_o),
		.res_valid_o (res_valid_o),
		.res_data_o  (res_data_o),
		.res_err_o   (res_err_o),
		.res_ready_i (res_ready_i)
	);

	axi_sram_rd_slave u_slave (
		.clk          (clk),
		.rst          (rst),
		.rd           (rd_bus),
		.sram_re_o    (sram_re),
		.sram_idx_o   (sram_idx),
		.sram_rdata_i (sram_rdata)
	);

	sram_bank u_sram (
		.clk      (clk),
		.we_i     (load_we_i),
		.widx_w_i (load_idx_i),
		.wdata_i  (load_data_i),
		.wstrb_i  (load_strb_i),
		.re_i     (sram_re),
		.widx_r_i (sram_idx),
		.rdata_o  (sram_rdata)
	);

endmodule

/* tb_sram_subsys.sv */
// ----------------------------------------
// testbench for the sram read subsystem
// loads the bank, issues word reads and
// checks results against a shadow memory
// run from sources.f with tb_sram_subsys
// as top module
// ----------------------------------------
module tb_sram_subsys;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_pkg::*;

	localparam int TIMEOUT = 200;

	logic              clk;
	logic              rst;
	logic              req_valid;
	logic [ADDR_W-1:0] req_addr;
	logic              req_ready;
	logic              res_valid;
	logic [DATA_W-1:0] res_data;
	logic              res_err;
	logic              res_ready;
	logic              load_we;
	logic [WIDX_W-1:0] load_idx;
	logic [DATA_W-1:0] load_data;
	logic [STRB_W-1:0] load_strb;

	// mirror of the bank contents
	logic [DATA_W-1:0] shadow [MEM_WORDS];
	// expected results in request order
	logic [DATA_W-1:0] exp_data_q [$];
	logic              exp_err_q [$];
	logic [WIDX_W-1:0] loaded [$];
	logic [31:0]       lcg_state;
	logic              random_stall;
	// one error counter per process
	int main_errs;
	int result_errs;
	int stall_errs;
	int err_mark;
	int result_count;
	int pass_tests;
	int fail_tests;

	sram_subsys_top i_dut (
		.clk         (clk),
		.rst         (rst),
		.req_valid_i (req_valid),
		.req_addr_i  (req_addr),
		.req_ready_o (req_ready),
		.res_valid_o (res_valid),
		.res_data_o  (res_data),
		.res_err_o   (res_err),
		.res_ready_i (res_ready),
		.load_we_i   (load_we),
		.load_idx_i  (load_idx),
		.load_data_i (load_data),
		.load_strb_i (load_strb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// byte lanes with a strobe bit take the new data
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
		input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] word;
		word = old_word;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) begin
				word[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return word;
	endfunction

	function automatic int total_errors();
		return main_errs + result_errs + stall_errs;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("TIMEOUT at %0t ns: %s after %0d cycles", $time, what, TIMEOUT);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	// next cycle, inputs change 1 ns after the edge
	task automatic step();
		logic [31:0] r;
		@(posedge clk);
		#1;
		if (random_stall) begin
			r = next_rand();
			res_ready = r[20];
		end
	endtask

	task automatic load_word(input logic [WIDX_W-1:0] idx, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
		load_we   = 1'b1;
		load_idx  = idx;
		load_data = data;
		load_strb = strb;
		shadow[idx] = merge_bytes(shadow[idx], data, strb);
		step();
		load_we = 1'b0;
	endtask

	// expected value fixed when the request is taken
	task automatic send_request(input logic [ADDR_W-1:0] addr);
		int waited;
		waited = 0;
		req_valid = 1'b1;
		req_addr  = addr;
		while (!req_ready && waited < TIMEOUT) begin
			step();
			waited++;
		end
		if (!req_ready) begin
			abort_on_timeout("req_ready_o stayed low");
		end
		// word select from bits 9:2, bank ends at byte 1024
		if (addr < MEM_WORDS * 4) begin
			exp_data_q.push_back(shadow[addr[9:2]]);
			exp_err_q.push_back(1'b0);
		end else begin
			exp_data_q.push_back('0);
			exp_err_q.push_back(1'b1);
		end
		step();
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 && waited < TIMEOUT) begin
			step();
			waited++;
		end
		if (exp_data_q.size() != 0) begin
			abort_on_timeout("results still outstanding");
		end
	endtask

	task automatic finish_test(input string name);
		if (total_errors() == err_mark) begin
			pass_tests++;
			$display("test %s: ok", name);
		end else begin
			fail_tests++;
			$display("test %s: %0d errors", name, total_errors() - err_mark);
		end
		err_mark = total_errors();
	endtask

	// result taken at the coming edge, sampled mid cycle
	always @(negedge clk) begin : check_results
		logic [DATA_W-1:0] exp_d;
		logic              exp_e;
		if (!rst && res_valid && res_ready) begin
			if (exp_data_q.size() == 0) begin
				$display("ERROR at %0t ns: result delivered with no request outstanding", $time);
				result_errs++;
			end else begin
				exp_d = exp_data_q.pop_front();
				exp_e = exp_err_q.pop_front();
				assert (res_data == exp_d) else begin
					report_mismatch("res_data_o", res_data, exp_d);
					result_errs++;
				end
				assert (res_err == exp_e) else begin
					report_mismatch("res_err_o", {31'd0, res_err}, {31'd0, exp_e});
					result_errs++;
				end
				result_count++;
			end
		end
	end

	// a stalled result keeps valid and payload
	a_res_stable: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_err))
		else begin
			$display("ERROR at %0t ns: result changed or dropped while stalled", $time);
			stall_errs++;
		end

	initial begin
		logic [31:0]       r;
		logic [STRB_W-1:0] strb;
		int                n;
		lcg_state    = 32'd49;
		main_errs    = 0;
		result_errs  = 0;
		stall_errs   = 0;
		err_mark     = 0;
		result_count = 0;
		pass_tests   = 0;
		fail_tests   = 0;
		random_stall = 1'b0;
		req_valid    = 1'b0;
		req_addr     = '0;
		res_ready    = 1'b1;
		load_we      = 1'b0;
		load_idx     = '0;
		load_data    = '0;
		load_strb    = '0;
		// bank starts all zero
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = '0;
		end
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		assert (!res_valid) else begin
			report_mismatch("res_valid_o", 32'd1, 32'd0);
			main_errs++;
		end
		step();
		assert (req_ready) else begin
			report_mismatch("req_ready_o", 32'd0, 32'd1);
			main_errs++;
		end
		finish_test("reset_state");

		// full words at random indices, read back with random low bits
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			loaded.push_back(r[15:8]);
			load_word(r[15:8], next_rand(), 4'hF);
		end
		foreach (loaded[i]) begin
			r = next_rand();
			send_request({22'd0, loaded[i], r[1:0]});
		end
		wait_drain();
		finish_test("loaded_words");

		// partial strobes over the same words
		for (int i = 0; i < 12; i++) begin
			r = next_rand();
			strb = r[11:8];
			if (strb == 4'hF) begin
				strb = 4'h6;
			end
			load_word(loaded[r[3:0]], next_rand(), strb);
		end
		foreach (loaded[i]) begin
			send_request({22'd0, loaded[i], 2'b00});
		end
		wait_drain();
		finish_test("partial_strobes");

		// at or past byte 1024, then normal reads again
		send_request(32'd1024);
		send_request(32'hFFFF_FFFC);
		for (int i = 0; i < 4; i++) begin
			send_request(next_rand() | 32'h0000_0400);
		end
		for (int i = 0; i < 4; i++) begin
			send_request({22'd0, loaded[i], 2'b00});
		end
		wait_drain();
		finish_test("out_of_range");

		// random stalls, one request in four out of range
		random_stall = 1'b1;
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			if (r[5:4] == 2'b00) begin
				send_request(r | 32'h0000_0400);
			end else begin
				send_request({22'd0, loaded[r[3:0]], r[9:8]});
			end
		end
		wait_drain();
		random_stall = 1'b0;
		// hold register, slave beat and two queue entries
		res_ready = 1'b0;
		for (int i = 0; i < 4; i++) begin
			send_request({22'd0, loaded[i+4], 2'b00});
		end
		repeat (4) step();
		assert (!req_ready) else begin
			report_mismatch("req_ready_o", 32'd1, 32'd0);
			main_errs++;
		end
		res_ready = 1'b1;
		wait_drain();
		finish_test("back_pressure");

		// empty system, result visible in the 4th cycle after acceptance
		send_request({22'd0, loaded[5], 2'b00});
		n = 1;
		while (!res_valid && n < TIMEOUT) begin
			step();
			n++;
		end
		if (!res_valid) begin
			abort_on_timeout("res_valid_o never rose");
		end
		assert (n == 4) else begin
			report_mismatch("cycles to res_valid_o", 32'(n), 32'd4);
			main_errs++;
		end
		wait_drain();
		finish_test("latency");

		$display("tests %0d, passed %0d, failed %0d, results checked %0d, errors %0d",
			pass_tests + fail_tests, pass_tests, fail_tests, result_count, total_errors());
		if (total_errors() == 0 && fail_tests == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
